// File: run.sh
#!/bin/sh
# build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module pipeline_tb -o sim_pipeline \
	|| { echo "compile failed"; exit 1; }

./obj_dir/sim_pipeline | tee /dev/stderr | grep -q "^Everything OK$" \
	&& echo "simulation passed" \
	|| { echo "simulation did not pass"; exit 1; }

// File: source/alu.sv
`default_nettype none

module alu (
	input  pipe_pkg::opcode_t opcode,
	input  pipe_pkg::word_t   a,
	input  pipe_pkg::word_t   b,
	output pipe_pkg::word_t   result
);

	always_comb begin
		case (opcode)
			pipe_pkg::op_add, pipe_pkg::op_addi, pipe_pkg::op_lw,
			pipe_pkg::op_sw, pipe_pkg::op_jal:
				result = a + b;                  // sums, addresses, link
			pipe_pkg::op_sub:
				result = a - b;
			pipe_pkg::op_and, pipe_pkg::op_andi:
				result = a & b;
			pipe_pkg::op_or, pipe_pkg::op_ori:
				result = a | b;
			pipe_pkg::op_xor, pipe_pkg::op_xori:
				result = a ^ b;
			pipe_pkg::op_sll:
				result = a << b[4:0];            // shift amount from imm
			pipe_pkg::op_srl:
				result = a >> b[4:0];            // logical
			default:
				result = '0;                     // branches, j, jr, bubbles
		endcase
	end

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`default_nettype none

module decode_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  pipe_pkg::opcode_t   opcode,
	input  pipe_pkg::reg_addr_t rs1,
	input  pipe_pkg::reg_addr_t rs2,
	input  pipe_pkg::reg_addr_t rd,
	input  pipe_pkg::imm_t      imm,
	input  pipe_pkg::pc_t       pc,
	input  logic                stall,
	input  pipe_pkg::cmp_sel_t  cmp_sel_a,
	input  pipe_pkg::cmp_sel_t  cmp_sel_b,
	input  pipe_pkg::tgt_sel_t  target_sel,
	input  pipe_pkg::word_t     id_ex_alu_out,
	input  pipe_pkg::word_t     ex_mem_value,
	input  pipe_pkg::word_t     wb_value,
	input  logic                wb_we,
	input  pipe_pkg::reg_addr_t wb_rd,
	input  pipe_pkg::word_t     wb_data,
	dest_bus_if.producer        dest,
	output logic                branch_taken,
	output logic                jump,
	output pipe_pkg::pc_t       branch_target,
	output pipe_pkg::opcode_t   ex_opcode,
	output pipe_pkg::reg_addr_t ex_rs1,
	output pipe_pkg::reg_addr_t ex_rs2,
	output pipe_pkg::reg_addr_t ex_rd,
	output pipe_pkg::word_t     ex_a,
	output pipe_pkg::word_t     ex_b,
	output pipe_pkg::imm_t      ex_imm,
	output pipe_pkg::pc_t       ex_pc
);

	pipe_pkg::word_t rf_a;
	pipe_pkg::word_t rf_b;
	pipe_pkg::word_t opnd_a;    // forwarded rs1, feeds comparator and id/ex
	pipe_pkg::word_t opnd_b;
	pipe_pkg::word_t tgt_base;
	logic            accept;
	logic            writes_rd;

	register_file rf0 (
		.clk(clk), .rst_n(rst_n),
		.ra1(rs1), .ra2(rs2),
		.we(wb_we), .wa(wb_rd), .wd(wb_data),
		.rd1(rf_a), .rd2(rf_b)
	);

	assign accept = in_valid && !stall;

	// ------------------------------
	// operand and target muxes
	always_comb begin
		case (cmp_sel_a)
			pipe_pkg::cmp_id_ex:  opnd_a = id_ex_alu_out;
			pipe_pkg::cmp_ex_mem: opnd_a = ex_mem_value;
			pipe_pkg::cmp_mem_wb: opnd_a = wb_value;
			default:              opnd_a = rf_a;
		endcase
		case (cmp_sel_b)
			pipe_pkg::cmp_id_ex:  opnd_b = id_ex_alu_out;
			pipe_pkg::cmp_ex_mem: opnd_b = ex_mem_value;
			pipe_pkg::cmp_mem_wb: opnd_b = wb_value;
			default:              opnd_b = rf_b;
		endcase
		case (target_sel)
			3'b000:             tgt_base = id_ex_alu_out;  // jr, rs1 still in ex
			3'b001:             tgt_base = ex_mem_value;
			3'b010:             tgt_base = wb_value;
			3'b011:             tgt_base = rf_a;
			pipe_pkg::tgt_pc:   tgt_base = pc;
			default:            tgt_base = '0;             // j, jal
		endcase
	end

	assign branch_target = tgt_base + pipe_pkg::word_t'(signed'(imm));

	// branch decision, only for an instruction taken this cycle
	assign branch_taken = accept &&
		(((opcode == pipe_pkg::op_beq) && (opnd_a == opnd_b)) ||
		 ((opcode == pipe_pkg::op_bne) && (opnd_a != opnd_b)));
	assign jump = accept && ((opcode == pipe_pkg::op_j) || (opcode == pipe_pkg::op_jal) ||
		(opcode == pipe_pkg::op_jr));

	always_comb begin
		case (opcode)
			pipe_pkg::op_add, pipe_pkg::op_sub, pipe_pkg::op_and, pipe_pkg::op_or,
			pipe_pkg::op_xor, pipe_pkg::op_addi, pipe_pkg::op_andi, pipe_pkg::op_ori,
			pipe_pkg::op_xori, pipe_pkg::op_sll, pipe_pkg::op_srl, pipe_pkg::op_lw,
			pipe_pkg::op_jal:
				writes_rd = 1'b1;
			default:
				writes_rd = 1'b0;
		endcase
	end

	// ------------------------------
	// id/ex register, stall or no input gives a bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_opcode             <= '0;
			dest.id_ex_wr         <= 1'b0;
			dest.id_ex_rd_is_load <= 1'b0;
		end else begin
			ex_opcode             <= accept ? opcode : '0;  // opcode 0 does nothing downstream
			dest.id_ex_wr         <= accept && writes_rd;
			dest.id_ex_rd_is_load <= accept && (opcode == pipe_pkg::op_lw);
		end
	end

	always_ff @(posedge clk) begin
		ex_rs1 <= rs1;
		ex_rs2 <= rs2;
		ex_rd  <= rd;
		ex_a   <= opnd_a;   // already forwarded, covers the wb write race
		ex_b   <= opnd_b;
		ex_imm <= imm;
		ex_pc  <= pc;
	end

	assign dest.id_ex_rd = ex_rd;

endmodule

`default_nettype wire

// File: source/dest_bus_if.sv
`default_nettype none

// destination register info of the three pipeline registers past decode
interface dest_bus_if;

	pipe_pkg::reg_addr_t id_ex_rd;
	logic                id_ex_wr;
	logic                id_ex_rd_is_load;  // lw sitting in ex, data not ready yet
	pipe_pkg::reg_addr_t ex_mem_rd;
	logic                ex_mem_wr;
	logic                ex_mem_is_load;    // ex_mem value comes from dmem
	pipe_pkg::reg_addr_t mem_wb_rd;
	logic                mem_wb_wr;

	// decode drives the id_ex fields, exec/mem the rest
	modport producer (output id_ex_rd, id_ex_wr, id_ex_rd_is_load,
		ex_mem_rd, ex_mem_wr, ex_mem_is_load, mem_wb_rd, mem_wb_wr);

	modport consumer (input id_ex_rd, id_ex_wr, id_ex_rd_is_load,
		ex_mem_rd, ex_mem_wr, ex_mem_is_load, mem_wb_rd, mem_wb_wr);

endinterface

`default_nettype wire

// File: source/exec_mem_stage.sv
`default_nettype none

module exec_mem_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  pipe_pkg::opcode_t    ex_opcode,
	input  pipe_pkg::reg_addr_t  ex_rd,
	input  pipe_pkg::word_t      ex_a,
	input  pipe_pkg::word_t      ex_b,
	input  pipe_pkg::imm_t       ex_imm,
	input  pipe_pkg::pc_t        ex_pc,
	input  pipe_pkg::fwd_a_t     forward_a,
	input  pipe_pkg::fwd_b_t     forward_b,
	input  pipe_pkg::store_sel_t store_rs2_forward,
	dest_bus_if.producer         dest,
	output pipe_pkg::word_t      id_ex_alu_out,
	output pipe_pkg::word_t      ex_mem_value,
	output pipe_pkg::word_t      wb_value,
	output logic                 wb_valid,
	output pipe_pkg::reg_addr_t  wb_rd
);

	pipe_pkg::word_t alu_a;
	pipe_pkg::word_t alu_b;
	pipe_pkg::word_t store_data;
	pipe_pkg::word_t ex_mem_alu;
	pipe_pkg::word_t ex_mem_store;
	logic            ex_mem_is_store;
	pipe_pkg::word_t mem_rdata;
	pipe_pkg::word_t mem_wb_alu;
	pipe_pkg::word_t mem_wb_load;
	logic            mem_wb_is_load;
	logic [$clog2(pipe_pkg::dmem_depth)-1:0] dmem_idx;

	pipe_pkg::word_t dmem [pipe_pkg::dmem_depth];

	// ------------------------------
	// execute
	always_comb begin
		case (forward_a)
			pipe_pkg::fwd_a_pc:     alu_a = ex_pc;
			pipe_pkg::fwd_a_ex_mem: alu_a = ex_mem_value;
			pipe_pkg::fwd_a_mem_wb: alu_a = wb_value;
			default:                alu_a = ex_a;
		endcase
		case (forward_b)
			pipe_pkg::fwd_b_imm:    alu_b = pipe_pkg::word_t'(signed'(ex_imm));
			pipe_pkg::fwd_b_one:    alu_b = 32'd1;
			pipe_pkg::fwd_b_ex_mem: alu_b = ex_mem_value;
			pipe_pkg::fwd_b_mem_wb: alu_b = wb_value;
			default:                alu_b = ex_b;
		endcase
		case (store_rs2_forward)
			pipe_pkg::store_ex_mem: store_data = ex_mem_value;
			pipe_pkg::store_mem_wb: store_data = wb_value;
			default:                store_data = ex_b;
		endcase
	end

	alu alu0 (.opcode(ex_opcode), .a(alu_a), .b(alu_b), .result(id_ex_alu_out));

	// ------------------------------
	// ex/mem register and data memory
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dest.ex_mem_wr      <= 1'b0;
			dest.ex_mem_is_load <= 1'b0;
			ex_mem_is_store     <= 1'b0;
		end else begin
			dest.ex_mem_wr      <= dest.id_ex_wr;
			dest.ex_mem_is_load <= dest.id_ex_rd_is_load;
			ex_mem_is_store     <= (ex_opcode == pipe_pkg::op_sw);
		end
	end

	always_ff @(posedge clk) begin
		dest.ex_mem_rd <= ex_rd;
		ex_mem_alu     <= id_ex_alu_out;
		ex_mem_store   <= store_data;
	end

	assign dmem_idx  = ex_mem_alu[7:2];    // word index
	assign mem_rdata = dmem[dmem_idx];    // async read

	always_ff @(posedge clk) begin
		if (ex_mem_is_store)
			dmem[dmem_idx] <= ex_mem_store;
	end

	assign ex_mem_value = dest.ex_mem_is_load ? mem_rdata : ex_mem_alu;

	// ------------------------------
	// mem/wb register and write-back mux
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dest.mem_wb_wr <= 1'b0;
			mem_wb_is_load <= 1'b0;
		end else begin
			dest.mem_wb_wr <= dest.ex_mem_wr;
			mem_wb_is_load <= dest.ex_mem_is_load;
		end
	end

	always_ff @(posedge clk) begin
		dest.mem_wb_rd <= dest.ex_mem_rd;
		mem_wb_alu     <= ex_mem_alu;
		mem_wb_load    <= mem_rdata;
	end

	assign wb_value = mem_wb_is_load ? mem_wb_load : mem_wb_alu;
	assign wb_valid = dest.mem_wb_wr;
	assign wb_rd    = dest.mem_wb_rd;

endmodule

`default_nettype wire

// File: source/forward_unit.sv
`default_nettype none

module forward_unit (
	input  pipe_pkg::opcode_t    if_id_opcode,
	input  pipe_pkg::reg_addr_t  if_id_rs1,
	input  pipe_pkg::reg_addr_t  if_id_rs2,
	input  pipe_pkg::opcode_t    id_ex_opcode,
	input  pipe_pkg::reg_addr_t  id_ex_rs1,
	input  pipe_pkg::reg_addr_t  id_ex_rs2,
	dest_bus_if.consumer         dest,
	output pipe_pkg::fwd_a_t     forward_a,
	output pipe_pkg::fwd_b_t     forward_b,
	output pipe_pkg::store_sel_t store_rs2_forward,
	output pipe_pkg::cmp_sel_t   cmp_sel_a,
	output pipe_pkg::cmp_sel_t   cmp_sel_b,
	output pipe_pkg::tgt_sel_t   target_sel
);

	// producer writes a nonzero rd that the consumer reads
	function automatic logic hit(input logic wr, input pipe_pkg::reg_addr_t rd,
		input pipe_pkg::reg_addr_t rs);
		return wr && (rd != '0) && (rd == rs);
	endfunction

	// decode consumers see three producers, nearest first
	function automatic pipe_pkg::cmp_sel_t dec_sel(input pipe_pkg::reg_addr_t rs);
		if (hit(dest.id_ex_wr, dest.id_ex_rd, rs))
			return pipe_pkg::cmp_id_ex;
		else if (hit(dest.ex_mem_wr, dest.ex_mem_rd, rs))
			return pipe_pkg::cmp_ex_mem;
		else if (hit(dest.mem_wb_wr, dest.mem_wb_rd, rs))
			return pipe_pkg::cmp_mem_wb;
		return pipe_pkg::cmp_rf;
	endfunction

	logic ex_hit_a;   // rs1 of ex matches ex_mem
	logic wb_hit_a;   // rs1 of ex matches mem_wb
	logic ex_hit_b;
	logic wb_hit_b;
	logic b_is_imm;   // second operand is the immediate

	assign ex_hit_a = hit(dest.ex_mem_wr, dest.ex_mem_rd, id_ex_rs1);
	assign wb_hit_a = hit(dest.mem_wb_wr, dest.mem_wb_rd, id_ex_rs1);
	assign ex_hit_b = hit(dest.ex_mem_wr, dest.ex_mem_rd, id_ex_rs2);
	assign wb_hit_b = hit(dest.mem_wb_wr, dest.mem_wb_rd, id_ex_rs2);

	always_comb begin
		case (id_ex_opcode)
			pipe_pkg::op_addi, pipe_pkg::op_andi, pipe_pkg::op_ori, pipe_pkg::op_xori,
			pipe_pkg::op_lw, pipe_pkg::op_sw, pipe_pkg::op_sll, pipe_pkg::op_srl:
				b_is_imm = 1'b1;
			default:
				b_is_imm = 1'b0;
		endcase
	end

	// ------------------------------
	// execute stage consumers
	always_comb begin
		if (id_ex_opcode == pipe_pkg::op_jal) forward_a = pipe_pkg::fwd_a_pc;  // link = pc + 1
		else if (ex_hit_a)                    forward_a = pipe_pkg::fwd_a_ex_mem;
		else if (wb_hit_a)                    forward_a = pipe_pkg::fwd_a_mem_wb;
		else                                  forward_a = pipe_pkg::fwd_a_rf;

		if (b_is_imm)                              forward_b = pipe_pkg::fwd_b_imm;
		else if (id_ex_opcode == pipe_pkg::op_jal) forward_b = pipe_pkg::fwd_b_one;
		else if (ex_hit_b)                         forward_b = pipe_pkg::fwd_b_ex_mem;
		else if (wb_hit_b)                         forward_b = pipe_pkg::fwd_b_mem_wb;
		else                                       forward_b = pipe_pkg::fwd_b_rf;

		// sw data path ignores the immediate override on b
		if (ex_hit_b)      store_rs2_forward = pipe_pkg::store_ex_mem;
		else if (wb_hit_b) store_rs2_forward = pipe_pkg::store_mem_wb;
		else               store_rs2_forward = pipe_pkg::store_rf;
	end

	// ------------------------------
	// decode stage consumers
	assign cmp_sel_a = dec_sel(if_id_rs1);
	assign cmp_sel_b = dec_sel(if_id_rs2);

	always_comb begin
		case (if_id_opcode)
			pipe_pkg::op_jr:                  target_sel = {1'b0, dec_sel(if_id_rs1)};  // register base
			pipe_pkg::op_j, pipe_pkg::op_jal: target_sel = pipe_pkg::tgt_zero;
			default:                          target_sel = pipe_pkg::tgt_pc;  // pc-relative branch
		endcase
	end

endmodule

`default_nettype wire

// File: source/hazard_unit.sv
`default_nettype none

module hazard_unit (
	input  pipe_pkg::opcode_t   if_id_opcode,
	input  pipe_pkg::reg_addr_t if_id_rs1,
	input  pipe_pkg::reg_addr_t if_id_rs2,
	input  logic                in_valid,
	dest_bus_if.consumer        dest,
	output logic                stall
);

	logic reads_rs1;
	logic reads_rs2;

	// j and jal take no register, everything else reads rs1
	assign reads_rs1 = !(if_id_opcode == pipe_pkg::op_j || if_id_opcode == pipe_pkg::op_jal);

	always_comb begin
		case (if_id_opcode)
			pipe_pkg::op_add, pipe_pkg::op_sub, pipe_pkg::op_and, pipe_pkg::op_or,
			pipe_pkg::op_xor, pipe_pkg::op_sw, pipe_pkg::op_beq, pipe_pkg::op_bne:
				reads_rs2 = 1'b1;
			default:
				reads_rs2 = 1'b0;
		endcase
	end

	// lw in ex cannot feed decode yet, hold one cycle until it reaches mem
	assign stall = in_valid && dest.id_ex_rd_is_load && (dest.id_ex_rd != '0) &&
		((reads_rs1 && (if_id_rs1 == dest.id_ex_rd)) ||
		 (reads_rs2 && (if_id_rs2 == dest.id_ex_rd)));

endmodule

`default_nettype wire

// File: source/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	// ------------------------------
	// widths and basic types
	localparam int word_w = 32;
	localparam int reg_addr_w = 5;
	localparam int opcode_w = 7;
	localparam int imm_w = 16;

	typedef logic [word_w-1:0]     word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;
	typedef logic [opcode_w-1:0]   opcode_t;
	typedef logic [imm_w-1:0]      imm_t;  // sign-extended at the point of use
	typedef logic [word_w-1:0]     pc_t;   // word address, jal links pc + 1

	// ------------------------------
	// opcodes, 0 is left free for pipeline bubbles
	localparam opcode_t op_add  = 7'd1;
	localparam opcode_t op_sub  = 7'd2;
	localparam opcode_t op_and  = 7'd3;
	localparam opcode_t op_or   = 7'd4;
	localparam opcode_t op_xor  = 7'd5;
	localparam opcode_t op_addi = 7'd6;
	localparam opcode_t op_andi = 7'd7;
	localparam opcode_t op_ori  = 7'd8;
	localparam opcode_t op_xori = 7'd9;
	localparam opcode_t op_sll  = 7'd10;
	localparam opcode_t op_srl  = 7'd11;
	localparam opcode_t op_lw   = 7'd12;
	localparam opcode_t op_sw   = 7'd13;
	localparam opcode_t op_beq  = 7'd14;
	localparam opcode_t op_bne  = 7'd15;
	localparam opcode_t op_j    = 7'd16;
	localparam opcode_t op_jal  = 7'd17;
	localparam opcode_t op_jr   = 7'd18;

	// ------------------------------
	// forwarding mux selects
	typedef logic [1:0] fwd_a_t;
	localparam fwd_a_t fwd_a_pc     = 2'b00;  // jal link base
	localparam fwd_a_t fwd_a_ex_mem = 2'b01;
	localparam fwd_a_t fwd_a_mem_wb = 2'b10;
	localparam fwd_a_t fwd_a_rf     = 2'b11;

	typedef logic [2:0] fwd_b_t;
	localparam fwd_b_t fwd_b_imm    = 3'b000;
	localparam fwd_b_t fwd_b_one    = 3'b001;  // jal adds one to pc
	localparam fwd_b_t fwd_b_ex_mem = 3'b010;
	localparam fwd_b_t fwd_b_mem_wb = 3'b011;
	localparam fwd_b_t fwd_b_rf     = 3'b100;

	typedef logic [1:0] store_sel_t;
	localparam store_sel_t store_rf     = 2'b00;
	localparam store_sel_t store_ex_mem = 2'b01;
	localparam store_sel_t store_mem_wb = 2'b10;

	typedef logic [1:0] cmp_sel_t;
	localparam cmp_sel_t cmp_id_ex  = 2'b00;  // alu output of the instruction in ex
	localparam cmp_sel_t cmp_ex_mem = 2'b01;
	localparam cmp_sel_t cmp_mem_wb = 2'b10;
	localparam cmp_sel_t cmp_rf     = 2'b11;

	typedef logic [2:0] tgt_sel_t;  // low codes follow cmp_sel_t
	localparam tgt_sel_t tgt_pc   = 3'b100;
	localparam tgt_sel_t tgt_zero = 3'b101;  // absolute target for j and jal

	localparam int dmem_depth = 64;  // words

endpackage

`default_nettype wire

// File: source/pipeline_top.sv
`default_nettype none

module pipeline_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  pipe_pkg::opcode_t   opcode,
	input  pipe_pkg::reg_addr_t rs1,
	input  pipe_pkg::reg_addr_t rs2,
	input  pipe_pkg::reg_addr_t rd,
	input  pipe_pkg::imm_t      imm,
	input  pipe_pkg::pc_t       pc,
	output logic                stall,
	output logic                branch_taken,
	output logic                jump,
	output pipe_pkg::pc_t       branch_target,
	output logic                wb_valid,
	output pipe_pkg::reg_addr_t wb_rd,
	output pipe_pkg::word_t     wb_value
);

	// forwarding selects
	pipe_pkg::fwd_a_t     forward_a;
	pipe_pkg::fwd_b_t     forward_b;
	pipe_pkg::store_sel_t store_rs2_forward;
	pipe_pkg::cmp_sel_t   cmp_sel_a;
	pipe_pkg::cmp_sel_t   cmp_sel_b;
	pipe_pkg::tgt_sel_t   target_sel;

	// forwarded data
	pipe_pkg::word_t id_ex_alu_out;
	pipe_pkg::word_t ex_mem_value;

	// id/ex fields
	pipe_pkg::opcode_t   ex_opcode;
	pipe_pkg::reg_addr_t ex_rs1;
	pipe_pkg::reg_addr_t ex_rs2;
	pipe_pkg::reg_addr_t ex_rd;
	pipe_pkg::word_t     ex_a;
	pipe_pkg::word_t     ex_b;
	pipe_pkg::imm_t      ex_imm;
	pipe_pkg::pc_t       ex_pc;

	dest_bus_if dest_bus ();

	forward_unit fwd0 (
		.if_id_opcode(opcode), .if_id_rs1(rs1), .if_id_rs2(rs2),
		.id_ex_opcode(ex_opcode), .id_ex_rs1(ex_rs1), .id_ex_rs2(ex_rs2),
		.dest(dest_bus.consumer),
		.forward_a(forward_a), .forward_b(forward_b),
		.store_rs2_forward(store_rs2_forward),
		.cmp_sel_a(cmp_sel_a), .cmp_sel_b(cmp_sel_b), .target_sel(target_sel)
	);

	hazard_unit haz0 (
		.if_id_opcode(opcode), .if_id_rs1(rs1), .if_id_rs2(rs2),
		.in_valid(in_valid), .dest(dest_bus.consumer), .stall(stall)
	);

	decode_stage dec0 (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid),
		.opcode(opcode), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .pc(pc),
		.stall(stall), .cmp_sel_a(cmp_sel_a), .cmp_sel_b(cmp_sel_b), .target_sel(target_sel),
		.id_ex_alu_out(id_ex_alu_out), .ex_mem_value(ex_mem_value), .wb_value(wb_value),
		.wb_we(wb_valid), .wb_rd(wb_rd), .wb_data(wb_value),   // write-back loops to rf
		.dest(dest_bus.producer),
		.branch_taken(branch_taken), .jump(jump), .branch_target(branch_target),
		.ex_opcode(ex_opcode), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
		.ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm), .ex_pc(ex_pc)
	);

	exec_mem_stage exm0 (
		.clk(clk), .rst_n(rst_n),
		.ex_opcode(ex_opcode), .ex_rd(ex_rd), .ex_a(ex_a), .ex_b(ex_b),
		.ex_imm(ex_imm), .ex_pc(ex_pc),
		.forward_a(forward_a), .forward_b(forward_b), .store_rs2_forward(store_rs2_forward),
		.dest(dest_bus.producer),
		.id_ex_alu_out(id_ex_alu_out), .ex_mem_value(ex_mem_value), .wb_value(wb_value),
		.wb_valid(wb_valid), .wb_rd(wb_rd)
	);

endmodule

`default_nettype wire

// File: source/register_file.sv
`default_nettype none

module register_file (
	input  logic                clk,
	input  logic                rst_n,
	input  pipe_pkg::reg_addr_t ra1,
	input  pipe_pkg::reg_addr_t ra2,
	input  logic                we,
	input  pipe_pkg::reg_addr_t wa,
	input  pipe_pkg::word_t     wd,
	output pipe_pkg::word_t     rd1,
	output pipe_pkg::word_t     rd2
);

	pipe_pkg::word_t regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && (wa != '0)) begin  // r0 stays zero
			regs[wa] <= wd;
		end
	end

	// same-cycle write is picked up by mem_wb forwarding instead
	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

endmodule

`default_nettype wire

// File: tb.f
source/pipe_pkg.sv
source/dest_bus_if.sv
source/forward_unit.sv
source/hazard_unit.sv
source/register_file.sv
source/alu.sv
source/decode_stage.sv
source/exec_mem_stage.sv
source/pipeline_top.sv
verification/tb_clock.sv
verification/pipeline_tb.sv

// File: verification/pipeline_tb.sv
`default_nettype none

module pipeline_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int reset_cycles = 16;
	localparam int max_instr = 400;  // directed tests plus dmem fill plus random mix with margin
	localparam int n_random = 200;

	logic                clk;
	logic                rst_n;
	logic                in_valid;
	pipe_pkg::opcode_t   opcode;
	pipe_pkg::reg_addr_t rs1;
	pipe_pkg::reg_addr_t rs2;
	pipe_pkg::reg_addr_t rd;
	pipe_pkg::imm_t      imm;
	pipe_pkg::pc_t       pc;
	logic                stall;
	logic                branch_taken;
	logic                jump;
	pipe_pkg::pc_t       branch_target;
	logic                wb_valid;
	pipe_pkg::reg_addr_t wb_rd;
	pipe_pkg::word_t     wb_value;

	// reference model state
	pipe_pkg::word_t     mregs [32];
	pipe_pkg::word_t     mmem [64];
	pipe_pkg::reg_addr_t exp_rd [$];
	pipe_pkg::word_t     exp_val [$];
	int                  exp_cyc [$];  // cycle in which the write must show
	logic                prev_stall;

	int                  errors;
	int                  tests_failed;
	int                  tests_passed;
	int                  issued;
	int                  seed;
	int                  st;
	int                  cycle;        // falling edges seen so far
	pipe_pkg::pc_t       pc_next;

	tb_clock clk_gen (.clk(clk));

	pipeline_top dut0 (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid),
		.opcode(opcode), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .pc(pc),
		.stall(stall), .branch_taken(branch_taken), .jump(jump),
		.branch_target(branch_target),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_value(wb_value)
	);

	function automatic pipe_pkg::word_t sext(input pipe_pkg::imm_t i);
		return {{16{i[15]}}, i};
	endfunction

	// ------------------------------
	// reference step for an accepted instruction in program order
	task automatic model_step();
		pipe_pkg::word_t a;
		pipe_pkg::word_t b;
		pipe_pkg::word_t s;
		pipe_pkg::word_t res;
		pipe_pkg::word_t tgt;
		logic            wr;
		logic            taken;
		logic            jmp;
		a = mregs[rs1];
		b = mregs[rs2];
		s = sext(imm);
		res = '0;
		tgt = pc + s;  // branch default
		wr = 1'b1;
		taken = 1'b0;
		jmp = 1'b0;
		case (opcode)
			pipe_pkg::op_add:  res = a + b;
			pipe_pkg::op_sub:  res = a - b;
			pipe_pkg::op_and:  res = a & b;
			pipe_pkg::op_or:   res = a | b;
			pipe_pkg::op_xor:  res = a ^ b;
			pipe_pkg::op_addi: res = a + s;
			pipe_pkg::op_andi: res = a & s;
			pipe_pkg::op_ori:  res = a | s;
			pipe_pkg::op_xori: res = a ^ s;
			pipe_pkg::op_sll:  res = a << imm[4:0];
			pipe_pkg::op_srl:  res = a >> imm[4:0];
			pipe_pkg::op_lw:   res = mmem[(a + s) >> 2 & 32'h3f];
			pipe_pkg::op_jal: begin
				res = pc + 1;  // link
				jmp = 1'b1;
				tgt = s;
			end
			default: wr = 1'b0;
		endcase
		case (opcode)
			pipe_pkg::op_sw:  mmem[(a + s) >> 2 & 32'h3f] = b;
			pipe_pkg::op_beq: taken = (a == b);
			pipe_pkg::op_bne: taken = (a != b);
			pipe_pkg::op_j: begin
				jmp = 1'b1;
				tgt = s;
			end
			pipe_pkg::op_jr: begin
				jmp = 1'b1;
				tgt = a + s;
			end
			default: ;
		endcase
		assert (branch_taken == taken && jump == jmp) else begin
			$display("FAIL %0t: op %0d taken=%b jump=%b, expected %b %b", $time,
				opcode, branch_taken, jump, taken, jmp);
			errors++;
		end
		if (taken || jmp) begin
			assert (branch_target == tgt) else begin
				$display("FAIL %0t: op %0d target %h, expected %h", $time, opcode,
					branch_target, tgt);
				errors++;
			end
		end
		if (wr) begin
			exp_rd.push_back(rd);   // r0 writes still show on wb_valid
			exp_val.push_back(res);
			exp_cyc.push_back(cycle + 3);  // ex, mem, then wb
			if (rd != 0)
				mregs[rd] = res;
		end
	endtask

	// checks at the falling edge where all DUT outputs have settled
	always @(negedge clk) begin
		cycle++;
		if (rst_n) begin
			if (wb_valid) begin
				assert (exp_rd.size() > 0) else begin
					$display("write-back at %0t with no write expected", $time);
					errors++;
				end
				if (exp_rd.size() > 0) begin
					assert (wb_rd == exp_rd[0] && wb_value == exp_val[0]) else begin
						$display("FAIL %0t: wb r%0d=%h, expected r%0d=%h", $time,
							wb_rd, wb_value, exp_rd[0], exp_val[0]);
						errors++;
					end
					assert (cycle == exp_cyc[0]) else begin
						$display("FAIL %0t: wb r%0d in cycle %0d, expected cycle %0d", $time,
							wb_rd, cycle, exp_cyc[0]);
						errors++;
					end
					void'(exp_rd.pop_front());
					void'(exp_val.pop_front());
					void'(exp_cyc.pop_front());
				end
			end
			assert (!(stall && prev_stall)) else begin
				$display("stall held longer than one cycle at %0t", $time);
				errors++;
			end
			prev_stall = stall;
			if (in_valid && !stall)
				model_step();
		end
	end

	// ------------------------------
	// stimulus helpers
	task automatic issue(input pipe_pkg::opcode_t op, input pipe_pkg::reg_addr_t a,
		input pipe_pkg::reg_addr_t b, input pipe_pkg::reg_addr_t d, input pipe_pkg::imm_t i,
		output int stalls);
		@(posedge clk);
		in_valid <= 1'b1;
		opcode   <= op;
		rs1      <= a;
		rs2      <= b;
		rd       <= d;
		imm      <= i;
		pc       <= pc_next;
		pc_next  = pc_next + 1;
		issued++;
		stalls = 0;
		@(negedge clk);
		while (stall) begin  // fields held until accepted
			stalls++;
			@(negedge clk);
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		@(posedge clk);
		in_valid <= 1'b0;
		@(negedge clk);
		while (exp_rd.size() != 0)
			@(negedge clk);
		if (errors == err_before) begin
			tests_passed++;
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	task automatic random_instr();
		logic [31:0] r;
		r = $random(seed);
		issue(pipe_pkg::opcode_t'(1 + r[7:0] % 18), pipe_pkg::reg_addr_t'(r[10:8]),
			pipe_pkg::reg_addr_t'(r[13:11]), pipe_pkg::reg_addr_t'(r[16:14]),
			pipe_pkg::imm_t'($random(seed)), st);
	endtask

	// watchdog sized from the instruction budget
	initial begin
		#((reset_cycles + 20 * max_instr) * 100);
		$display("timeout, the pipeline did not finish within the cycle budget");
		$display("Something failed");
		$finish;
	end

	// ------------------------------
	// main sequence
	initial begin
		int e;
		seed = 50126;
		errors = 0;
		tests_failed = 0;
		tests_passed = 0;
		issued = 0;
		cycle = 0;
		pc_next = 32'h100;
		prev_stall = 1'b0;
		for (int k = 0; k < 32; k++)
			mregs[k] = '0;
		for (int k = 0; k < 64; k++)
			mmem[k] = '0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		opcode = '0;
		rs1 = '0;
		rs2 = '0;
		rd = '0;
		imm = '0;
		pc = '0;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;

		e = errors;  // dependent alu chain at distances 1 to 3
		issue(pipe_pkg::op_addi, 0, 0, 1, 16'd5, st);
		issue(pipe_pkg::op_addi, 0, 0, 2, -16'sd3, st);
		issue(pipe_pkg::op_add, 1, 2, 3, 0, st);
		issue(pipe_pkg::op_sub, 3, 1, 4, 0, st);
		issue(pipe_pkg::op_and, 4, 3, 5, 0, st);
		issue(pipe_pkg::op_or, 5, 1, 6, 0, st);
		issue(pipe_pkg::op_xor, 6, 3, 7, 0, st);
		issue(pipe_pkg::op_xori, 7, 0, 8, 16'h00f0, st);
		issue(pipe_pkg::op_ori, 8, 0, 9, 16'h0301, st);
		issue(pipe_pkg::op_andi, 9, 0, 10, 16'hff0f, st);
		issue(pipe_pkg::op_sll, 10, 0, 11, 16'd3, st);
		issue(pipe_pkg::op_srl, 11, 0, 12, 16'd2, st);
		end_test("alu_forwarding", e);

		e = errors;  // r0 stays zero
		issue(pipe_pkg::op_addi, 1, 0, 0, 16'd9, st);
		issue(pipe_pkg::op_add, 0, 1, 13, 0, st);
		issue(pipe_pkg::op_or, 0, 0, 14, 0, st);
		end_test("r0_write", e);

		e = errors;  // load-use stall and store data forwarding
		issue(pipe_pkg::op_addi, 0, 0, 1, 16'd40, st);
		issue(pipe_pkg::op_addi, 0, 0, 2, 16'd77, st);
		issue(pipe_pkg::op_sw, 1, 2, 0, 16'd0, st);
		issue(pipe_pkg::op_lw, 1, 0, 3, 16'd0, st);
		issue(pipe_pkg::op_add, 3, 3, 4, 0, st);
		assert (st == 1) else begin
			$display("load-use stall lasted %0d cycles instead of one", st);
			errors++;
		end
		issue(pipe_pkg::op_lw, 1, 0, 5, 16'd0, st);
		issue(pipe_pkg::op_sw, 1, 5, 0, 16'd4, st);
		issue(pipe_pkg::op_lw, 1, 0, 6, 16'd4, st);
		end_test("load_store", e);

		e = errors;  // branches on operands 1 to 3 instructions back
		issue(pipe_pkg::op_addi, 0, 0, 1, 16'd12, st);
		issue(pipe_pkg::op_addi, 0, 0, 2, 16'd12, st);
		issue(pipe_pkg::op_beq, 1, 2, 0, 16'd8, st);
		issue(pipe_pkg::op_bne, 1, 2, 0, -16'sd4, st);
		issue(pipe_pkg::op_addi, 0, 0, 3, 16'd13, st);
		issue(pipe_pkg::op_add, 0, 0, 4, 0, st);
		issue(pipe_pkg::op_bne, 3, 1, 0, 16'd20, st);
		issue(pipe_pkg::op_beq, 3, 2, 0, 16'd20, st);
		end_test("branches", e);

		e = errors;  // jumps
		issue(pipe_pkg::op_addi, 0, 0, 6, 16'd100, st);
		issue(pipe_pkg::op_jr, 6, 0, 0, 16'd4, st);
		issue(pipe_pkg::op_j, 0, 0, 0, 16'd300, st);
		issue(pipe_pkg::op_jal, 0, 0, 31, 16'd50, st);
		issue(pipe_pkg::op_jr, 31, 0, 0, 16'd0, st);
		issue(pipe_pkg::op_add, 31, 0, 7, 0, st);
		end_test("jumps", e);

		e = errors;  // random registers and a dmem fill ahead of the random mix
		for (int k = 1; k < 8; k++)
			issue(pipe_pkg::op_addi, 0, 0, pipe_pkg::reg_addr_t'(k),
				pipe_pkg::imm_t'($random(seed)), st);
		for (int k = 0; k < 64; k++) begin
			// r9 is outside the random register range
			issue(pipe_pkg::op_addi, 0, 0, 9, pipe_pkg::imm_t'(16'h1357 + 1033 * k), st);
			issue(pipe_pkg::op_sw, 0, 9, 0, pipe_pkg::imm_t'(4 * k), st);
		end
		for (int k = 0; k < n_random; k++)
			random_instr();
		end_test("random_mix", e);

		$display("%0d tests passed, %0d failed, %0d instructions", tests_passed,
			tests_failed, issued);
		if (errors == 0 && tests_failed == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`default_nettype none

// free running clock for the testbench, 100 ns period
module tb_clock (
	output logic clk
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;  // half period
	end

endmodule

`default_nettype wire
